// File: common/fma_pkg.sv
package fma_pkg;

   // operand and accumulator widths
   localparam int operand_w = 32;
   localparam int wide_w    = 2 * operand_w;

   // slots in the product delay line unless the top level overrides it
   localparam int default_delay = 4;

   // product as it leaves the multiplier and moves down the delay line
   typedef struct packed {
      logic              valid;
      logic [wide_w-1:0] value;
   } product_t;

   // accumulated sum at the top-level output
   typedef struct packed {
      logic              valid;
      logic [wide_w-1:0] sum;
   } result_t;

endpackage

// File: multiplier/wallace_tree_32x32.sv
`timescale 1ns/1ps

module wallace_tree_32x32 (
   input  logic [31:0] a,
   input  logic [31:0] b,
   output logic [63:0] sum_vec,
   output logic [63:0] carry_vec
);

   localparam int n_pp     = 32;
   localparam int n_layers = 8;

   typedef struct packed {
      logic [63:0] s;
      logic [63:0] c;
   } csa_t;

   // rows left after a given number of 3:2 layers
   function automatic int rows_after(input int layers);
      int n;
      n = n_pp;
      for (int l = 0; l < layers; l++) begin
         n = (n / 3) * 2 + (n % 3);
      end
      return n;
   endfunction

   function automatic csa_t half_add(input logic [63:0] x, input logic [63:0] y);
      csa_t r;
      r.s = x ^ y;
      r.c = x & y;
      return r;
   endfunction

   // one full adder per column, made of two half adders
   function automatic csa_t full_add(
      input logic [63:0] x,
      input logic [63:0] y,
      input logic [63:0] z
   );
      csa_t h1;
      csa_t h2;
      csa_t r;
      h1  = half_add(x, y);
      h2  = half_add(h1.s, z);
      r.s = h2.s;
      // carry lands one weight up, bit 63 falls off (product fits in 64 bits)
      r.c = (h1.c | h2.c) << 1;
      return r;
   endfunction

   logic [63:0] rows [n_layers+1][n_pp];

   // partial products, row i is a shifted by i when b[i] is set
   for (genvar i = 0; i < n_pp; i++) begin : g_pp
      assign rows[0][i] = b[i] ? ({32'b0, a} << i) : 64'b0;
   end

   // wallace layers: 32 -> 22 -> 15 -> 10 -> 7 -> 5 -> 4 -> 3 -> 2
   for (genvar lvl = 0; lvl < n_layers; lvl++) begin : g_layer
      localparam int n_in  = rows_after(lvl);
      localparam int n_grp = n_in / 3;
      localparam int n_out = rows_after(lvl + 1);

      for (genvar g = 0; g < n_grp; g++) begin : g_csa
         csa_t fa;

         assign fa = full_add(rows[lvl][3*g], rows[lvl][3*g+1], rows[lvl][3*g+2]);
         assign rows[lvl+1][2*g]   = fa.s;
         assign rows[lvl+1][2*g+1] = fa.c;
      end

      // leftover rows skip this layer
      for (genvar r = 2 * n_grp; r < n_out; r++) begin : g_pass
         assign rows[lvl+1][r] = rows[lvl][r + n_grp];
      end

      // slots no longer in use
      for (genvar r = n_out; r < n_pp; r++) begin : g_idle
         assign rows[lvl+1][r] = 64'b0;
      end
   end

   assign sum_vec   = rows[n_layers][0];
   assign carry_vec = rows[n_layers][1];

endmodule

// File: adder/prefix_adder_64.sv
`timescale 1ns/1ps

module prefix_adder_64 (
   input  logic [63:0] x,
   input  logic [63:0] y,
   output logic [63:0] sum
);

   // bit-level generate and propagate
   logic [63:0] g0;
   logic [63:0] p0;
   // after the two brent-kung levels
   logic [63:0] g1;
   logic [63:0] p1;
   logic [63:0] g2;
   logic [63:0] p2;
   // kogge-stone levels over the 4-bit group columns
   logic [63:0] gk [5];
   logic [63:0] pk [5];
   // group generate from bit 0 up to each bit
   logic [63:0] gf;
   logic [63:0] carry;

   assign g0 = x & y;
   assign p0 = x ^ y;

   // bk level 1, odd bits take their lower neighbour
   always_comb begin
      g1 = g0;
      p1 = p0;
      for (int i = 1; i < 64; i += 2) begin
         g1[i] = g0[i] | (p0[i] & g0[i-1]);
         p1[i] = p0[i] & p0[i-1];
      end
   end

   // bk level 2, every fourth bit spans 4 bits
   always_comb begin
      g2 = g1;
      p2 = p1;
      for (int i = 3; i < 64; i += 4) begin
         g2[i] = g1[i] | (p1[i] & g1[i-2]);
         p2[i] = p1[i] & p1[i-2];
      end
   end

   // ks over the 16 group columns, distances 4, 8, 16, 32
   always_comb begin
      gk[0] = g2;
      pk[0] = p2;
      for (int l = 0; l < 4; l++) begin
         gk[l+1] = gk[l];
         pk[l+1] = pk[l];
         for (int i = 3; i < 64; i += 4) begin
            if (i >= (4 << l)) begin
               gk[l+1][i] = gk[l][i] | (pk[l][i] & gk[l][i - (4 << l)]);
               pk[l+1][i] = pk[l][i] & pk[l][i - (4 << l)];
            end
         end
      end
   end

   // fill in the bits between the group columns
   always_comb begin
      gf = gk[4];
      // bits 4k+1 lean on the finished column two below
      for (int i = 5; i < 64; i += 4) begin
         gf[i] = g1[i] | (p1[i] & gf[i-2]);
      end
      // even bits lean on the odd bit right below, already complete
      for (int i = 2; i < 64; i += 2) begin
         gf[i] = g0[i] | (p0[i] & gf[i-1]);
      end
   end

   // no carry in; the carry out of bit 63 is dropped
   assign carry = {gf[62:0], 1'b0};
   assign sum   = p0 ^ carry;

endmodule

// File: multiplier/product_stage.sv
`timescale 1ns/1ps

module product_stage (
   input  logic [fma_pkg::operand_w-1:0] a,
   input  logic [fma_pkg::operand_w-1:0] b,
   input  logic                          in_valid,
   output fma_pkg::product_t             product
);

   import fma_pkg::*;

   // carry-save pair out of the tree
   logic [wide_w-1:0] sum_vec;
   logic [wide_w-1:0] carry_vec;
   logic [wide_w-1:0] full_product;

   wallace_tree_32x32 u_tree (
      .a         (a),
      .b         (b),
      .sum_vec   (sum_vec),
      .carry_vec (carry_vec)
   );

   // resolve the two rows into the final product
   prefix_adder_64 u_cpa (
      .x   (sum_vec),
      .y   (carry_vec),
      .sum (full_product)
   );

   // tag with the operand valid, no register here
   always_comb begin
      product.valid = in_valid;
      product.value = full_product;
   end

endmodule

// File: design/product_delay_line.sv
`timescale 1ns/1ps

module product_delay_line #(
   parameter int product_delay = fma_pkg::default_delay
) (
   input  logic              clk,
   input  logic              rst,
   input  fma_pkg::product_t product_in,
   output fma_pkg::product_t product_out
);

   import fma_pkg::*;

   product_t slots [product_delay];

   if (product_delay < 1 || product_delay > 8) begin : g_range_check
      $error("product_delay must be within 1 to 8");
   end

   // slot 0 takes the new product, everything moves up one
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         for (int i = 0; i < product_delay; i++) begin
            slots[i] <= '0;
         end
      end else begin
         slots[0] <= product_in;
         for (int i = 1; i < product_delay; i++) begin
            slots[i] <= slots[i-1];
         end
      end
   end

   // oldest slot feeds the accumulator
   assign product_out = slots[product_delay-1];

   // an x valid would propagate into result.valid and the model pairing
   a_valid_known : assert property (
      @(posedge clk) disable iff (!rst)
      !$isunknown(product_out.valid)
   ) else $error("delayed product valid is unknown");

endmodule

// File: design/accumulate_stage.sv
`timescale 1ns/1ps

module accumulate_stage (
   input  logic                        clk,
   input  logic                        rst,
   input  fma_pkg::product_t           product,
   input  logic [fma_pkg::wide_w-1:0]  c,
   output fma_pkg::result_t            result
);

   import fma_pkg::*;

   logic [wide_w-1:0] c_reg;
   logic [wide_w-1:0] sum_next;

   // delayed product plus the addend from one cycle back
   prefix_adder_64 u_acc_add (
      .x   (product.value),
      .y   (c_reg),
      .sum (sum_next)
   );

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         c_reg  <= '0;
         result <= '0;
      end else begin
         c_reg        <= c;
         result.valid <= product.valid;
         result.sum   <= sum_next;
      end
   end

   // valid goes through exactly one register in this stage
   a_valid_follows : assert property (
      @(posedge clk) disable iff (!rst)
      result.valid == $past(product.valid)
   ) else $error("result valid does not follow product valid by one cycle");

endmodule

// File: design/fma_top.sv
`timescale 1ns/1ps

module fma_top #(
   parameter int product_delay = fma_pkg::default_delay
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [fma_pkg::operand_w-1:0] a,
   input  logic [fma_pkg::operand_w-1:0] b,
   input  logic                          in_valid,
   input  logic [fma_pkg::wide_w-1:0]    c,
   output fma_pkg::result_t              result
);

   import fma_pkg::*;

   // combinational product, then the same product product_delay slots later
   product_t product_now;
   product_t product_late;

   product_stage u_producer (
      .a        (a),
      .b        (b),
      .in_valid (in_valid),
      .product  (product_now)
   );

   product_delay_line #(
      .product_delay (product_delay)
   ) u_buffer (
      .clk         (clk),
      .rst         (rst),
      .product_in  (product_now),
      .product_out (product_late)
   );

   accumulate_stage u_consumer (
      .clk     (clk),
      .rst     (rst),
      .product (product_late),
      .c       (c),
      .result  (result)
   );

endmodule

// File: sim/fma_tb_tasks.svh
task automatic check_result(input result_t got, input result_t expected);
   if (got !== expected) begin
      error_count++;
      $display("MISMATCH result: got valid=%h sum=%h, expected valid=%h sum=%h at %0t",
               got.valid, got.sum, expected.valid, expected.sum, $time);
   end
endtask

task automatic check_valid(input logic got, input logic expected);
   if (got !== expected) begin
      error_count++;
      $display("MISMATCH result.valid: got %h, expected %h at %0t", got, expected, $time);
   end
endtask

// expected output right after edge k since reset release
function automatic result_t model_result(input int k);
   result_t           r;
   int                j;
   logic [wide_w-1:0] product;
   r = '0;
   // operation sampled delay edges earlier completes here
   j = k - delay;
   if (j >= 0) begin
      product = {{operand_w{1'b0}}, hist_a[j]} * {{operand_w{1'b0}}, hist_b[j]};
      r.valid = hist_v[j];
      // addend pairs with the operands delay-1 edges later
      r.sum   = product + hist_c[j + delay - 1];
   end
   return r;
endfunction

task automatic drive_cycle(
   input logic [operand_w-1:0] op_a,
   input logic [operand_w-1:0] op_b,
   input logic                 op_valid,
   input logic [wide_w-1:0]    addend
);
   @(posedge clk);
   #1;
   a        = op_a;
   b        = op_b;
   in_valid = op_valid;
   c        = addend;
endtask

task automatic drive_random(input logic op_valid);
   logic [operand_w-1:0] op_a;
   logic [operand_w-1:0] op_b;
   logic [wide_w-1:0]    addend;
   op_a   = $random(seed);
   op_b   = $random(seed);
   addend = {$random(seed), $random(seed)};
   drive_cycle(op_a, op_b, op_valid, addend);
endtask

task automatic idle_cycles(input int n);
   repeat (n) drive_cycle('0, '0, 1'b0, '0);
endtask

// one operation with c held steady and a wait for its result
task automatic run_single(
   input logic [operand_w-1:0] op_a,
   input logic [operand_w-1:0] op_b,
   input logic [wide_w-1:0]    addend,
   input logic [wide_w-1:0]    expected_sum
);
   result_t expected;
   int      cycles;
   bit      found;
   expected.valid = 1'b1;
   expected.sum   = expected_sum;
   cycles         = 0;
   found          = 1'b0;
   drive_cycle(op_a, op_b, 1'b1, addend);
   drive_cycle(op_a, op_b, 1'b0, addend);
   while (!found && cycles < wait_limit) begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
      found = result.valid;
   end
   if (!found) begin
      error_count++;
      $display("no valid result within %0d cycles of the operation", wait_limit);
   end else begin
      if (cycles != delay) begin
         error_count++;
         $display("result arrived after %0d cycles instead of %0d", cycles, delay);
      end
      check_result(result, expected);
      // valid lasts one cycle only
      @(negedge clk);
      check_valid(result.valid, 1'b0);
   end
endtask

task automatic single_operations();
   logic [operand_w-1:0] op_a;
   logic [operand_w-1:0] op_b;
   logic [wide_w-1:0]    addend;
   op_a   = 32'h1234_5678;
   op_b   = 32'h9abc_def0;
   addend = 64'h0000_0100_0000_0042;
   run_single(op_a, op_b, addend, {32'h0, op_a} * {32'h0, op_b} + addend);
   run_single(32'd3, 32'd7, 64'd5, 64'd26);
endtask

task automatic back_to_back_stream();
   repeat (stream_ops) drive_random(1'b1);
   idle_cycles(drain_cycles);
endtask

task automatic irregular_bubbles();
   int r;
   repeat (bubble_ops) begin
      r = $random(seed);
      drive_random(r[0]);
   end
   idle_cycles(drain_cycles);
endtask

task automatic wraparound_sums();
   run_single(32'hffff_ffff, 32'hffff_ffff, 64'hffff_ffff_ffff_ffff, 64'hffff_fffe_0000_0000);
   // sum of exactly 2^64 wraps to zero
   run_single(32'hffff_ffff, 32'hffff_ffff, 64'h0000_0001_ffff_ffff, 64'h0);
endtask

task automatic reset_during_traffic();
   repeat (traffic_ops) drive_random(1'b1);
   @(posedge clk);
   #1;
   rst = 1'b0;
   repeat (4) drive_random(1'b1);
   @(posedge clk);
   #1;
   rst      = 1'b1;
   in_valid = 1'b0;
   // nothing new in flight yet
   repeat (2 * delay) begin
      @(negedge clk);
      check_valid(result.valid, 1'b0);
   end
   repeat (traffic_ops) drive_random(1'b1);
   idle_cycles(drain_cycles);
endtask

// File: sim/fma_tb.sv
`timescale 1ns/1ps

module fma_tb;

   import fma_pkg::*;

   localparam int clk_period   = 10;
   localparam int reset_cycles = 10;
   localparam int delay        = default_delay;
   localparam int drain_cycles = delay + 2;
   localparam int stream_ops   = 200;
   localparam int bubble_ops   = 150;
   localparam int traffic_ops  = 20;
   // a single operation may take this long before it counts as lost
   localparam int wait_limit   = 4 * delay;
   localparam int single_len   = wait_limit + 4;
   localparam int total_cycles = reset_cycles + 4 * single_len + stream_ops + bubble_ops
                                 + 2 * traffic_ops + 4 + 6 * drain_cycles;

   logic                 clk;
   logic                 rst;
   logic [operand_w-1:0] a;
   logic [operand_w-1:0] b;
   logic                 in_valid;
   logic [wide_w-1:0]    c;
   result_t              result;

   int seed;
   int error_count;
   bit reset_applied;

   // inputs as sampled on each rising edge since reset was released
   logic [operand_w-1:0] hist_a [$];
   logic [operand_w-1:0] hist_b [$];
   logic                 hist_v [$];
   logic [wide_w-1:0]    hist_c [$];

   fma_top dut (
      .clk      (clk),
      .rst      (rst),
      .a        (a),
      .b        (b),
      .in_valid (in_valid),
      .c        (c),
      .result   (result)
   );

   `include "fma_tb_tasks.svh"

   initial begin : clock_gen
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   initial begin : watchdog
      #((total_cycles + 100) * clk_period);
      $display("timeout: tests did not finish within %0d cycles", total_cycles + 100);
      $display("** FAIL **");
      $finish;
   end

   // history restarts whenever an edge sees reset low
   always @(posedge clk) begin : sample_inputs
      if (!rst) begin
         reset_applied = 1'b1;
         hist_a.delete();
         hist_b.delete();
         hist_v.delete();
         hist_c.delete();
      end else begin
         hist_a.push_back(a);
         hist_b.push_back(b);
         hist_v.push_back(in_valid);
         hist_c.push_back(c);
      end
   end

   // compare with the model half a cycle after each edge
   always @(negedge clk) begin : check_output
      result_t expected;
      if (!rst) begin
         if (reset_applied) begin
            expected = '0;
            check_result(result, expected);
         end
      end else if (hist_a.size() > 0) begin
         expected = model_result(hist_a.size() - 1);
         check_valid(result.valid, expected.valid);
         // sums only matter where an operation completes
         if (expected.valid) begin
            check_result(result, expected);
         end
      end
   end

   initial begin : test_sequence
      seed          = 88893;
      error_count   = 0;
      reset_applied = 1'b0;
      rst           = 1'b0;
      a             = '0;
      b             = '0;
      in_valid      = 1'b0;
      c             = '0;
      repeat (reset_cycles) @(posedge clk);
      #1;
      rst = 1'b1;

      single_operations();
      back_to_back_stream();
      irregular_bubbles();
      wraparound_sums();
      reset_during_traffic();

      $display("tests done with %0d errors", error_count);
      if (error_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: verilog.f
+incdir+sim
common/fma_pkg.sv
multiplier/wallace_tree_32x32.sv
adder/prefix_adder_64.sv
multiplier/product_stage.sv
design/product_delay_line.sv
design/accumulate_stage.sv
design/fma_top.sv
sim/fma_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fma testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f verilog.f \
   --top-module fma_tb \
   -o fma_sim

./obj_dir/fma_sim | tee sim.log

if grep -qF '** PASS **' sim.log; then
   echo "simulation finished without errors"
else
   echo "simulation reported errors, see sim.log"
   exit 1
fi
